/* Bender.yml */
package:
  name: barrel

sources:
  - hw/barrel_pkg.sv
  - hw/barrel_ctrl.sv
  - hw/barrel_alu.sv
  - hw/program_mem.sv
  - hw/program_arbiter.sv
  - hw/host_axil.sv
  - hw/barrel_top.sv
  - target: simulation
    files:
      - verification/barrel_tb.sv

/* barrel.f */
hw/barrel_pkg.sv
hw/barrel_ctrl.sv
hw/barrel_alu.sv
hw/program_mem.sv
hw/program_arbiter.sv
hw/host_axil.sv
hw/barrel_top.sv
verification/barrel_tb.sv

/* hw/barrel_alu.sv */
module barrel_alu #(
    parameter int THREAD_COUNT = 4,
    localparam int THREAD_W = $clog2(THREAD_COUNT)
) (
    input  logic                clock,
    input  logic                rst,
    input  logic                issue_valid,
    input  logic [THREAD_W-1:0] issue_thread,
    input  barrel_pkg::instr_t  instr,
    output logic                take_jump,
    output barrel_pkg::acc_t    retire_acc
);

    barrel_pkg::acc_t    acc_file [THREAD_COUNT];
    barrel_pkg::opcode_e op;
    barrel_pkg::acc_t    imm;
    barrel_pkg::acc_t    acc_old;
    barrel_pkg::acc_t    acc_new;
    logic                acc_zero;
    logic                acc_positive;
    logic                jump_cond;

    assign op      = barrel_pkg::opcode_e'(instr[15:12]);
    assign imm     = {{($bits(barrel_pkg::acc_t) - 12){instr[11]}}, instr[11:0]};
    assign acc_old = acc_file[issue_thread];

    // Flags come from the value before this instruction.
    assign acc_zero     = acc_old == '0;
    assign acc_positive = !acc_old[$bits(barrel_pkg::acc_t)-1];

    always_comb begin
        acc_new   = acc_old;
        jump_cond = 1'b0;
        case (op)
            barrel_pkg::ldi: acc_new = imm;
            barrel_pkg::add: acc_new = acc_old + imm;
            barrel_pkg::sub: acc_new = acc_old - imm;
            barrel_pkg::jmp: jump_cond = 1'b1;
            barrel_pkg::jze: jump_cond = acc_zero;
            barrel_pkg::jnz: jump_cond = !acc_zero;
            barrel_pkg::jpo: jump_cond = acc_positive;
            barrel_pkg::jne: jump_cond = !acc_positive;
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int k = 0; k < THREAD_COUNT; k++) begin
                acc_file[k] <= '0;
            end
            take_jump <= 1'b0;
        end else begin
            if (issue_valid) begin
                acc_file[issue_thread] <= acc_new;
            end
            take_jump <= issue_valid && jump_cond;
        end
    end

    always_ff @(posedge clock) begin
        retire_acc <= acc_new;
    end

    jump_only_on_jump_op: assert property (@(posedge clock) disable iff (rst)
        take_jump |-> $past(issue_valid) && $past(op) inside {barrel_pkg::jmp,
            barrel_pkg::jze, barrel_pkg::jnz, barrel_pkg::jpo, barrel_pkg::jne});

endmodule

/* hw/barrel_ctrl.sv */
module barrel_ctrl #(
    parameter int THREAD_COUNT = 4,
    localparam int THREAD_W = $clog2(THREAD_COUNT)
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  run,
    input  barrel_pkg::instr_t    instr,
    output logic                  fetch_req,
    output barrel_pkg::pc_t       fetch_pc,
    output logic                  issue_valid,
    output logic [THREAD_W-1:0]   issue_thread,
    output logic                  retire_valid,
    output logic [THREAD_W-1:0]   retire_thread,
    output barrel_pkg::pc_t       retire_pc,
    input  logic                  take_jump
);

    logic [THREAD_W-1:0] issue_ptr;
    barrel_pkg::pc_t     pc_store [THREAD_COUNT];
    barrel_pkg::pc_t     issue_pc;
    barrel_pkg::pc_t     jump_target;

    // Fetch for the thread under the pointer whenever running.
    assign fetch_req = run;
    assign fetch_pc  = pc_store[issue_ptr];

    always_ff @(posedge clock) begin
        if (rst) begin
            issue_ptr <= '0;
        end else if (run) begin
            issue_ptr <= issue_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            issue_valid  <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            issue_valid  <= fetch_req;
            retire_valid <= issue_valid;
        end
    end

    // Thread and PC ride alongside the instruction.
    always_ff @(posedge clock) begin
        issue_thread  <= issue_ptr;
        issue_pc      <= fetch_pc;
        retire_thread <= issue_thread;
        retire_pc     <= issue_pc;
        jump_target   <= instr[7:0];
    end

    // Threads start spread evenly over the program space.
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int k = 0; k < THREAD_COUNT; k++) begin
                pc_store[k] <= barrel_pkg::pc_t'(k * (barrel_pkg::prog_words / THREAD_COUNT));
            end
        end else if (retire_valid) begin
            pc_store[retire_thread] <= take_jump ? jump_target : retire_pc + 1'b1;
        end
    end

    retire_matches_issue: assert property (@(posedge clock) disable iff (rst)
        retire_valid |-> $past(fetch_req, 2) && retire_thread == $past(issue_ptr, 2));

endmodule

/* hw/barrel_pkg.sv */
package barrel_pkg;

    // Program counter and program memory word index.
    typedef logic [7:0] pc_t;

    // Opcode in bits 15 to 12, operand in bits 11 to 0.
    typedef logic [15:0] instr_t;

    typedef logic signed [15:0] acc_t;

    // Codes 9 to 15 decode as nop.
    typedef enum logic [3:0] {
        nop = 4'd0,
        ldi = 4'd1,
        add = 4'd2,
        sub = 4'd3,
        jmp = 4'd4,
        jze = 4'd5,
        jnz = 4'd6,
        jpo = 4'd7,
        jne = 4'd8
    } opcode_e;

    typedef logic [11:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // Program word i sits at byte 4*i, data bits 15 to 0.
    localparam axil_addr_t prog_base = 12'h000;

    // Run register, bit 0.
    localparam axil_addr_t ctrl_addr = 12'h400;

    localparam int prog_words = 2 ** $bits(pc_t);

endpackage

/* hw/barrel_top.sv */
module barrel_top #(
    parameter int THREAD_COUNT = 4,
    localparam int THREAD_W = $clog2(THREAD_COUNT)
) (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   awvalid,
    output logic                   awready,
    input  barrel_pkg::axil_addr_t awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  barrel_pkg::axil_data_t wdata,
    output logic                   bvalid,
    input  logic                   bready,
    output logic [1:0]             bresp,
    input  logic                   arvalid,
    output logic                   arready,
    input  barrel_pkg::axil_addr_t araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output barrel_pkg::axil_data_t rdata,
    output logic [1:0]             rresp,
    output logic                   retire_valid,
    output logic [THREAD_W-1:0]    retire_thread,
    output barrel_pkg::pc_t        retire_pc,
    output barrel_pkg::acc_t       retire_acc
);

    logic                run;
    logic                fetch_req;
    barrel_pkg::pc_t     fetch_pc;
    logic                issue_valid;
    logic [THREAD_W-1:0] issue_thread;
    logic                take_jump;
    logic                host_req;
    logic                host_we;
    barrel_pkg::pc_t     host_addr;
    barrel_pkg::instr_t  host_wdata;
    logic                host_gnt;
    logic                host_rvalid;
    logic                mem_en;
    logic                mem_we;
    barrel_pkg::pc_t     mem_addr;
    barrel_pkg::instr_t  mem_wdata;
    barrel_pkg::instr_t  mem_rdata;

    barrel_ctrl #(.THREAD_COUNT(THREAD_COUNT)) u_ctrl (
        .clock(clock), .rst(rst), .run(run), .instr(mem_rdata),
        .fetch_req(fetch_req), .fetch_pc(fetch_pc),
        .issue_valid(issue_valid), .issue_thread(issue_thread),
        .retire_valid(retire_valid), .retire_thread(retire_thread),
        .retire_pc(retire_pc), .take_jump(take_jump)
    );

    barrel_alu #(.THREAD_COUNT(THREAD_COUNT)) u_alu (
        .clock(clock), .rst(rst), .issue_valid(issue_valid),
        .issue_thread(issue_thread), .instr(mem_rdata),
        .take_jump(take_jump), .retire_acc(retire_acc)
    );

    program_mem u_mem (
        .clock(clock), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

    program_arbiter u_arb (
        .clock(clock), .rst(rst), .fetch_req(fetch_req), .fetch_pc(fetch_pc),
        .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_gnt(host_gnt), .mem_en(mem_en),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .host_rvalid(host_rvalid)
    );

    host_axil u_host (
        .clock(clock), .rst(rst),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .run(run), .host_req(host_req), .host_we(host_we),
        .host_addr(host_addr), .host_wdata(host_wdata),
        .host_gnt(host_gnt), .host_rvalid(host_rvalid), .mem_rdata(mem_rdata)
    );

endmodule

/* hw/host_axil.sv */
module host_axil (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     awvalid,
    output logic                     awready,
    input  barrel_pkg::axil_addr_t   awaddr,
    input  logic                     wvalid,
    output logic                     wready,
    input  barrel_pkg::axil_data_t   wdata,
    output logic                     bvalid,
    input  logic                     bready,
    output logic [1:0]               bresp,
    input  logic                     arvalid,
    output logic                     arready,
    input  barrel_pkg::axil_addr_t   araddr,
    output logic                     rvalid,
    input  logic                     rready,
    output barrel_pkg::axil_data_t   rdata,
    output logic [1:0]               rresp,
    output logic                     run,
    output logic                     host_req,
    output logic                     host_we,
    output barrel_pkg::pc_t          host_addr,
    output barrel_pkg::instr_t       host_wdata,
    input  logic                     host_gnt,
    input  logic                     host_rvalid,
    input  barrel_pkg::instr_t       mem_rdata
);

    typedef enum logic [1:0] {idle, mem_wait, resp} state_e;

    state_e state;
    logic   resp_write;
    logic   write_sel;
    logic   read_sel;
    logic   wr_prog;
    logic   rd_prog;
    logic   wr_ctrl;
    logic   rd_ctrl;

    // Writes take precedence when both arrive together.
    assign write_sel = awvalid && wvalid;
    assign read_sel  = arvalid && !write_sel;
    assign wr_prog   = awaddr[11:10] == barrel_pkg::prog_base[11:10];
    assign rd_prog   = araddr[11:10] == barrel_pkg::prog_base[11:10];
    assign wr_ctrl   = awaddr == barrel_pkg::ctrl_addr;
    assign rd_ctrl   = araddr == barrel_pkg::ctrl_addr;

    assign host_req   = (state == idle) && ((write_sel && wr_prog) || (read_sel && rd_prog));
    assign host_we    = write_sel;
    assign host_addr  = write_sel ? awaddr[9:2] : araddr[9:2];
    assign host_wdata = wdata[15:0];

    // Program accesses wait here for the arbiter.
    assign awready = (state == idle) && write_sel && (!wr_prog || host_gnt);
    assign wready  = awready;
    assign arready = (state == idle) && read_sel && (!rd_prog || host_gnt);

    assign bvalid = (state == resp) && resp_write;
    assign rvalid = (state == resp) && !resp_write;
    assign bresp  = 2'b00;
    assign rresp  = 2'b00;

    always_ff @(posedge clock) begin
        if (rst) begin
            state      <= idle;
            resp_write <= 1'b0;
            run        <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (awready) begin
                        resp_write <= 1'b1;
                        if (wr_ctrl) begin
                            run <= wdata[0];
                        end
                        state <= wr_prog ? mem_wait : resp;
                    end else if (arready) begin
                        resp_write <= 1'b0;
                        state      <= rd_prog ? mem_wait : resp;
                    end
                end
                mem_wait: begin
                    if (resp_write || host_rvalid) begin
                        state <= resp;
                    end
                end
                default: begin
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == idle && arready) begin
            rdata <= rd_ctrl ? {31'b0, run} : '0;
        end else if (state == mem_wait && host_rvalid) begin
            rdata <= {16'b0, mem_rdata};
        end
    end

    bvalid_held: assert property (@(posedge clock) disable iff (rst)
        bvalid && !bready |=> bvalid);

endmodule

/* hw/program_arbiter.sv */
module program_arbiter (
    input  logic               clock,
    input  logic               rst,
    input  logic               fetch_req,
    input  barrel_pkg::pc_t    fetch_pc,
    input  logic               host_req,
    input  logic               host_we,
    input  barrel_pkg::pc_t    host_addr,
    input  barrel_pkg::instr_t host_wdata,
    output logic               host_gnt,
    output logic               mem_en,
    output logic               mem_we,
    output barrel_pkg::pc_t    mem_addr,
    output barrel_pkg::instr_t mem_wdata,
    output logic               host_rvalid
);

    // Fetch has fixed priority.
    assign host_gnt = host_req && !fetch_req;

    assign mem_en    = fetch_req || host_gnt;
    assign mem_we    = host_gnt && host_we;
    assign mem_addr  = fetch_req ? fetch_pc : host_addr;
    assign mem_wdata = host_wdata;

    // Next cycle's read data belongs to the host.
    always_ff @(posedge clock) begin
        if (rst) begin
            host_rvalid <= 1'b0;
        end else begin
            host_rvalid <= host_gnt && !host_we;
        end
    end

    one_owner: assert property (@(posedge clock) disable iff (rst)
        !(fetch_req && host_gnt));

endmodule

/* hw/program_mem.sv */
module program_mem (
    input  logic               clock,
    input  logic               mem_en,
    input  logic               mem_we,
    input  barrel_pkg::pc_t    mem_addr,
    input  barrel_pkg::instr_t mem_wdata,
    output barrel_pkg::instr_t mem_rdata
);

    barrel_pkg::instr_t words [barrel_pkg::prog_words];

    // Read before write; the old word on a write goes unused.
    always_ff @(posedge clock) begin
        if (mem_en) begin
            if (mem_we) begin
                words[mem_addr] <= mem_wdata;
            end
            mem_rdata <= words[mem_addr];
        end
    end

endmodule

/* verification/barrel_tb.sv */
module barrel_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int THREAD_COUNT = 4;
    localparam int settle = 5;
    localparam int axi_cycles = 6;
    localparam int run_cycles = 240;
    localparam int stall_cycles = 40;
    localparam int cycle_limit = 16 + 2 * barrel_pkg::prog_words * axi_cycles
                                 + run_cycles + stall_cycles + 200;

    logic                   clock = 1'b0;
    logic                   rst;
    logic                   awvalid;
    logic                   awready;
    barrel_pkg::axil_addr_t awaddr;
    logic                   wvalid;
    logic                   wready;
    barrel_pkg::axil_data_t wdata;
    logic                   bvalid;
    logic                   bready;
    logic [1:0]             bresp;
    logic                   arvalid;
    logic                   arready;
    barrel_pkg::axil_addr_t araddr;
    logic                   rvalid;
    logic                   rready;
    barrel_pkg::axil_data_t rdata;
    logic [1:0]             rresp;
    logic                   retire_valid;
    logic [1:0]             retire_thread;
    barrel_pkg::pc_t        retire_pc;
    barrel_pkg::acc_t       retire_acc;

    barrel_pkg::instr_t prog [barrel_pkg::prog_words];
    barrel_pkg::pc_t    model_pc [THREAD_COUNT];
    barrel_pkg::acc_t   model_acc [THREAD_COUNT];
    logic [31:0]        lfsr;
    logic [1:0]         next_thread;
    logic               run_window;
    logic               run_cleared;
    int                 errors;
    int                 checks;
    int                 retire_count;
    int                 cycle_count;

    barrel_top #(.THREAD_COUNT(THREAD_COUNT)) UUT (
        .clock(clock), .rst(rst),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .retire_valid(retire_valid), .retire_thread(retire_thread),
        .retire_pc(retire_pc), .retire_acc(retire_acc)
    );

    initial begin
        forever #10 clock = ~clock;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // One instruction of one thread; jump flags see the old accumulator.
    function automatic void ref_step(input barrel_pkg::instr_t ins,
                                     inout barrel_pkg::pc_t pc,
                                     inout barrel_pkg::acc_t acc);
        barrel_pkg::acc_t imm;
        logic             jump;
        imm  = {{4{ins[11]}}, ins[11:0]};
        jump = 1'b0;
        case (ins[15:12])
            4'd1: acc = imm;
            4'd2: acc = acc + imm;
            4'd3: acc = acc - imm;
            4'd4: jump = 1'b1;
            4'd5: jump = (acc == 0);
            4'd6: jump = (acc != 0);
            4'd7: jump = !acc[15];
            4'd8: jump = acc[15];
            default: ;
        endcase
        pc = jump ? ins[7:0] : pc + 8'd1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic write_axi(input barrel_pkg::axil_addr_t addr,
                             input barrel_pkg::axil_data_t data);
        logic done;
        @(negedge clock);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        done    = 1'b0;
        while (!done) begin
            #settle;
            done = awready && wready;
            @(negedge clock);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // Response held back for one more cycle.
        @(negedge clock);
        bready  = 1'b1;
        done    = 1'b0;
        while (!done) begin
            #settle;
            done = bvalid;
            if (done) begin
                check_value("bresp", bresp, 2'b00);
            end
            @(negedge clock);
        end
    endtask

    task automatic read_axi(input barrel_pkg::axil_addr_t addr,
                            output barrel_pkg::axil_data_t data);
        logic done;
        @(negedge clock);
        araddr  = addr;
        arvalid = 1'b1;
        done    = 1'b0;
        while (!done) begin
            #settle;
            done = arready;
            @(negedge clock);
        end
        arvalid = 1'b0;
        done    = 1'b0;
        while (!done) begin
            #settle;
            done = rvalid;
            if (done) begin
                data = rdata;
                check_value("rresp", rresp, 2'b00);
            end
            @(negedge clock);
        end
    endtask

    task automatic report_and_finish(input logic timed_out);
        $display("Checks: %0d, errors: %0d, retires: %0d", checks, errors, retire_count);
        if (errors == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // Compare every retire against the model.
    initial begin
        forever begin
            int t;
            @(negedge clock);
            t = next_thread;
            if (run_window) begin
                check_value("retire_valid", retire_valid, 1'b1);
            end
            if (retire_valid) begin
                check_value("retire_thread", retire_thread, next_thread);
                check_value("retire_pc", retire_pc, model_pc[t]);
                ref_step(prog[model_pc[t]], model_pc[t], model_acc[t]);
                check_value("retire_acc", retire_acc, model_acc[t]);
                next_thread = next_thread + 2'd1;
                retire_count++;
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the test did not finish within %0d clock cycles.", cycle_limit);
        report_and_finish(1'b1);
    end

    initial begin
        barrel_pkg::axil_data_t data;
        barrel_pkg::pc_t        stall_pc;
        barrel_pkg::instr_t     new_word;
        logic [3:0]             op;
        int                     snapshot;
        rst          = 1'b1;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        bready       = 1'b1;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b1;
        lfsr         = 32'h57f3;
        next_thread  = '0;
        run_window   = 1'b0;
        run_cleared  = 1'b0;
        errors       = 0;
        checks       = 0;
        retire_count = 0;
        for (int k = 0; k < THREAD_COUNT; k++) begin
            model_pc[k]  = barrel_pkg::pc_t'(k * (256 / THREAD_COUNT));
            model_acc[k] = '0;
        end
        repeat (16) @(negedge clock);
        rst = 1'b0;

        read_axi(barrel_pkg::ctrl_addr, data);
        check_value("rdata run after reset", data, 32'd0);

        // Upper data bits are set so the readback proves zero extension.
        for (int i = 0; i < barrel_pkg::prog_words; i++) begin
            op      = 4'(random_bits(4) % 9);
            prog[i] = {op, 12'(random_bits(12))};
            write_axi(barrel_pkg::axil_addr_t'(barrel_pkg::prog_base + 4 * i),
                      {16'hffff, prog[i]});
        end
        for (int i = 0; i < barrel_pkg::prog_words; i++) begin
            read_axi(barrel_pkg::axil_addr_t'(barrel_pkg::prog_base + 4 * i), data);
            check_value("rdata program word", data, {16'h0000, prog[i]});
        end

        write_axi(barrel_pkg::ctrl_addr, 32'd1);
        repeat (2) @(negedge clock);
        run_window = 1'b1;
        read_axi(barrel_pkg::ctrl_addr, data);
        check_value("rdata run while running", data, 32'd1);
        repeat (run_cycles) @(negedge clock);

        // A program read held off by fetch until run is cleared.
        stall_pc = barrel_pkg::pc_t'(random_bits(8));
        fork
            begin
                read_axi(barrel_pkg::axil_addr_t'(barrel_pkg::prog_base + 4 * stall_pc), data);
                check_value("run cleared before host grant", run_cleared, 1'b1);
                check_value("rdata stalled word", data, {16'h0000, prog[stall_pc]});
            end
            begin
                repeat (stall_cycles) @(negedge clock);
                run_window = 1'b0;
                write_axi(barrel_pkg::ctrl_addr, 32'd0);
                run_cleared = 1'b1;
            end
        join

        new_word = 16'(random_bits(16));
        write_axi(barrel_pkg::axil_addr_t'(barrel_pkg::prog_base + 4 * stall_pc),
                  {16'h0000, new_word});
        prog[stall_pc] = new_word;
        read_axi(barrel_pkg::axil_addr_t'(barrel_pkg::prog_base + 4 * stall_pc), data);
        check_value("rdata rewritten word", data, {16'h0000, new_word});
        read_axi(barrel_pkg::ctrl_addr, data);
        check_value("rdata run after stop", data, 32'd0);

        snapshot = retire_count;
        repeat (20) @(negedge clock);
        check_value("retire count after stop", retire_count, snapshot);
        check_value("enough retires", retire_count >= run_cycles, 1'b1);

        report_and_finish(1'b0);
    end

endmodule
